/* vlog.f */
+incdir+rtl
rtl/axi4_pkg.sv
rtl/ddr_test_pkg.sv
rtl/axi4_adrs_generator.sv
rtl/axi4_write_sequence.sv
rtl/axi4_read_sequence.sv
rtl/ddr_pattern_checker.sv
rtl/ddr_test_top.sv
bench/axi4_mem_model.sv
bench/tb_ddr_test.sv

/* Makefile */
# Verilator build of the DDR test engine bench
SRCS := $(filter %.sv,$(shell cat vlog.f)) $(wildcard rtl/*.svh)

obj_dir/Vtb_ddr_test: vlog.f $(SRCS)
	verilator --binary --assert --top-module tb_ddr_test -f vlog.f -Mdir obj_dir -o Vtb_ddr_test

run: obj_dir/Vtb_ddr_test
	./obj_dir/Vtb_ddr_test

clean:
	rm -rf obj_dir

.PHONY: run clean

/* bench/tb_ddr_test.sv */
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// Testbench for the DDR test engine against the AXI4 memory model
// Runs a clean pass, then a pass with one corrupted beat
// Concurrent assertions check channel order, payloads and final status
//--------------------------------------------------------------------------
`include "ddr_test_defs.svh"

module tb_ddr_test import axi4_pkg::*, ddr_test_pkg::*;;

	localparam int lp_clk_period = 20;
	localparam int lp_bursts     = (`DDR_STOP_ADRS - `DDR_START_ADRS) / `DDR_BURST_BYTES;
	localparam int lp_watchdog   = 64 * 40 * 2;	// Cycles for both runs

	logic        iCLK;
	logic        iRST;
	logic        start;
	axi4_aw_t    aw;
	axi4_w_t     w;
	axi4_b_t     b;
	axi4_ar_t    ar;
	axi4_r_t     r;
	logic        awvalid, awready, wvalid, wready, bvalid, bready;
	logic        arvalid, arready, rvalid, rready;
	ddr_status_t status;
	logic [2:0]  rand_bits;
	logic [31:0] lfsr = 32'h4a280edf;
	logic        fault_en;
	ddr_adrs_t   fault_adrs;
	logic        started;		// First start issued
	logic        fault_run;		// Second pass expects one error
	ddr_adrs_t   exp_aw;
	ddr_adrs_t   exp_ar;
	ddr_adrs_t   exp_w;			// Address of next W beat
	int          w_beats;
	int          b_cnt;			// B responses in this pass

	ddr_test_top DUT (
		.iCLK (iCLK), .iRST (iRST), .i_start (start),
		.o_aw (aw), .o_awvalid (awvalid), .i_awready (awready),
		.o_w  (w),  .o_wvalid  (wvalid),  .i_wready  (wready),
		.i_b  (b),  .i_bvalid  (bvalid),  .o_bready  (bready),
		.o_ar (ar), .o_arvalid (arvalid), .i_arready (arready),
		.i_r  (r),  .i_rvalid  (rvalid),  .o_rready  (rready),
		.o_status (status)
	);

	axi4_mem_model u_mem (
		.iCLK (iCLK), .iRST (iRST), .i_rand (rand_bits),
		.i_fault_en (fault_en), .i_fault_adrs (fault_adrs),
		.i_aw (aw), .i_awvalid (awvalid), .o_awready (awready),
		.i_w  (w),  .i_wvalid  (wvalid),  .o_wready  (wready),
		.o_b  (b),  .o_bvalid  (bvalid),  .i_bready  (bready),
		.i_ar (ar), .i_arvalid (arvalid), .o_arready (arready),
		.o_r  (r),  .o_rvalid  (rvalid),  .i_rready  (rready)
	);

	//----------------------------------------------------------------------
	// Helpers
	//----------------------------------------------------------------------
	// Taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	// Lane k is ((low 16 address bits >> 1) + k) ^ A5C3
	function automatic logic [63:0] expected_beat(input ddr_adrs_t adrs);
		logic [15:0] base;
		logic [63:0] data;
		int          k;
		base = {1'b0, adrs[15:1]};
		for (k = 0; k < 4; k++)
			data[k*16 +: 16] = (base + 16'(k)) ^ 16'hA5C3;
		return data;
	endfunction

	// Next address in the region, back to the start at the stop
	function automatic ddr_adrs_t step_region(input ddr_adrs_t adrs, input int step);
		ddr_adrs_t nxt;
		nxt = adrs + ddr_adrs_t'(step);
		return (nxt == `DDR_STOP_ADRS) ? `DDR_START_ADRS : nxt;
	endfunction

	task automatic report_error(input string line);
		$display("%s", line);
		$display("Some tests failed");
		$fatal(1, "Stopped at the first failing check");
	endtask

	task automatic pulse_start();
		@(negedge iCLK);
		start   = 1'b1;
		started = 1'b1;
		@(negedge iCLK);
		start   = 1'b0;
	endtask

	//----------------------------------------------------------------------
	// Clock, random ready bits and reference tracking
	//----------------------------------------------------------------------
	initial
	begin
		iCLK = 1'b0;
		forever #(lp_clk_period / 2) iCLK = ~iCLK;
	end

	always @(negedge iCLK)
	begin
		for (int i = 0; i < 3; i++)
		begin
			lfsr         = lfsr_next(lfsr);	// One step per bit
			rand_bits[i] = lfsr[0];
		end
	end

	always @(posedge iCLK)
	begin
		if (iRST)
		begin
			exp_aw  <= `DDR_START_ADRS;
			exp_ar  <= `DDR_START_ADRS;
			exp_w   <= `DDR_START_ADRS;
			w_beats <= 0;
			b_cnt   <= 0;
		end
		else
		begin
			if (awvalid && awready)
				exp_aw <= step_region(exp_aw, `DDR_BURST_BYTES);
			if (arvalid && arready)
				exp_ar <= step_region(exp_ar, `DDR_BURST_BYTES);
			if (wvalid && wready)
			begin
				exp_w   <= step_region(exp_w, `DDR_BUS_BYTES);
				w_beats <= w_beats + 1;
			end
			if (start)
				b_cnt <= 0;	// New pass
			else if (bvalid && bready)
				b_cnt <= b_cnt + 1;
		end
	end

	//----------------------------------------------------------------------
	// Checks
	//----------------------------------------------------------------------
	a_idle : assert property (@(posedge iCLK) disable iff (iRST)
		!started |-> !(awvalid || wvalid || bready || arvalid || rready
			|| DUT.w_wdone || status.done))
		else report_error($sformatf("MISMATCH at %0d ns: DUT not idle after reset", $time));

	a_aw : assert property (@(posedge iCLK) disable iff (iRST)
		(awvalid && awready) |-> (aw.addr == exp_aw) && (aw.len == 8'd3)
			&& (aw.size == 3'd3) && (aw.burst == 2'b01))
		else report_error($sformatf(
			"MISMATCH at %0d ns: AW addr %h len %0d size %0d burst %0d, expected addr %h",
			$time, aw.addr, aw.len, aw.size, aw.burst, exp_aw));

	a_ar : assert property (@(posedge iCLK) disable iff (iRST)
		(arvalid && arready) |-> (ar.addr == exp_ar) && (ar.len == 8'd3)
			&& (ar.size == 3'd3) && (ar.burst == 2'b01))
		else report_error($sformatf(
			"MISMATCH at %0d ns: AR addr %h len %0d size %0d burst %0d, expected addr %h",
			$time, ar.addr, ar.len, ar.size, ar.burst, exp_ar));

	a_wlast : assert property (@(posedge iCLK) disable iff (iRST)
		(wvalid && wready)
			|-> (w.last == ((w_beats % `DDR_BURST_LEN) == `DDR_BURST_LEN - 1)))
		else report_error($sformatf("MISMATCH at %0d ns: W last %0b on beat %0d",
			$time, w.last, w_beats));

	a_wdata : assert property (@(posedge iCLK) disable iff (iRST)
		(wvalid && wready) |-> (w.data == expected_beat(exp_w)) && (&w.strb))
		else report_error($sformatf("MISMATCH at %0d ns: W data %h at %h, expected %h",
			$time, w.data, exp_w, expected_beat(exp_w)));

	a_ar_order : assert property (@(posedge iCLK) disable iff (iRST)
		arvalid |-> (b_cnt == lp_bursts))
		else report_error($sformatf("MISMATCH at %0d ns: AR before write pass done", $time));

	a_status : assert property (@(posedge iCLK) disable iff (iRST)
		$rose(status.done) |-> (status.pass == !fault_run)
			&& (status.err_cnt == (fault_run ? 8'd1 : 8'd0)))
		else report_error($sformatf("MISMATCH at %0d ns: pass %0b errors %0d, fault run %0b",
			$time, status.pass, status.err_cnt, fault_run));

	// Valid and payload held under back-pressure
	a_aw_hold : assert property (@(posedge iCLK) disable iff (iRST)
		(awvalid && !awready) |=> (awvalid && $stable(aw)))
		else report_error($sformatf("MISMATCH at %0d ns: AW changed before ready", $time));

	a_w_hold : assert property (@(posedge iCLK) disable iff (iRST)
		(wvalid && !wready) |=> (wvalid && $stable(w)))
		else report_error($sformatf("MISMATCH at %0d ns: W changed before ready", $time));

	a_ar_hold : assert property (@(posedge iCLK) disable iff (iRST)
		(arvalid && !arready) |=> (arvalid && $stable(ar)))
		else report_error($sformatf("MISMATCH at %0d ns: AR changed before ready", $time));

	//----------------------------------------------------------------------
	// Stimulus and watchdog
	//----------------------------------------------------------------------
	initial
	begin
		iRST       = 1'b1;
		start      = 1'b0;
		rand_bits  = 3'b000;
		fault_en   = 1'b0;
		fault_adrs = 32'h120;
		started    = 1'b0;
		fault_run  = 1'b0;
		repeat (2) @(negedge iCLK);	// Two reset cycles
		iRST = 1'b0;
		repeat (4) @(negedge iCLK);	// Idle window
		pulse_start();
		wait (status.done);
		repeat (2) @(negedge iCLK);	// Clean status sampled on the edge after done
		fault_en  = 1'b1;		// Corrupt one beat in pass two
		fault_run = 1'b1;
		pulse_start();
		wait (status.done);
		repeat (3) @(negedge iCLK);
		$display("All tests passed");
		$finish;
	end

	initial
	begin
		#(lp_watchdog * lp_clk_period);
		report_error("Timeout: status done was not reached before the watchdog expired");
	end

endmodule

/* bench/axi4_mem_model.sv */
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// AXI4 slave memory standing in for the DDR device
// One burst per channel at a time, readys gated by random bits
// A single beat address can be corrupted on store for fault tests
//--------------------------------------------------------------------------
`include "ddr_test_defs.svh"

module axi4_mem_model import axi4_pkg::*; (
	input  logic                       iCLK,
	input  logic                       iRST,
	input  logic [2:0]                 i_rand,		// AW, W and AR ready enables
	input  logic                       i_fault_en,
	input  logic [`DDR_ADRS_WIDTH-1:0] i_fault_adrs,
	// Write address channel
	input  axi4_aw_t                   i_aw,
	input  logic                       i_awvalid,
	output logic                       o_awready,
	// Write data channel
	input  axi4_w_t                    i_w,
	input  logic                       i_wvalid,
	output logic                       o_wready,
	// Write response channel
	output axi4_b_t                    o_b,
	output logic                       o_bvalid,
	input  logic                       i_bready,
	// Read address channel
	input  axi4_ar_t                   i_ar,
	input  logic                       i_arvalid,
	output logic                       o_arready,
	// Read data channel
	output axi4_r_t                    o_r,
	output logic                       o_rvalid,
	input  logic                       i_rready
);

	localparam int lp_depth    = (`DDR_STOP_ADRS - `DDR_START_ADRS) / `DDR_BUS_BYTES;
	localparam int lp_idx_bits = $clog2(lp_depth);

	typedef logic [lp_idx_bits-1:0] mem_idx_t;

	logic [`DDR_BUS_WIDTH-1:0]  r_mem [0:lp_depth-1];	// One entry per beat
	logic [`DDR_ADRS_WIDTH-1:0] r_wr_adrs;		// Next W beat address
	logic                       r_wr_busy;		// AW taken, beats pending
	logic                       r_bvalid;
	logic [`DDR_ADRS_WIDTH-1:0] r_rd_adrs;
	logic                       r_rd_busy;
	logic [7:0]                 r_rd_cnt;
	logic [7:0]                 r_rd_len;
	logic [`DDR_BUS_WIDTH-1:0]  w_wr_data;
	logic                       q_w_fire;
	logic                       q_r_fire;

	// Byte address to beat slot
	function automatic mem_idx_t beat_index(input logic [`DDR_ADRS_WIDTH-1:0] adrs);
		return mem_idx_t'((adrs - `DDR_START_ADRS) / `DDR_BUS_BYTES);
	endfunction

	//----------------------------------------------------------------------
	// Write side
	//----------------------------------------------------------------------
	assign o_awready = !r_wr_busy && !r_bvalid && i_rand[0];
	assign o_wready  = r_wr_busy && i_rand[1];	// Data only after its address
	assign q_w_fire  = i_wvalid && o_wready;

	// Bit 0 flipped at the faulty address
	assign w_wr_data = (i_fault_en && (r_wr_adrs == i_fault_adrs))
		? {i_w.data[`DDR_BUS_WIDTH-1:1], ~i_w.data[0]} : i_w.data;

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			r_wr_busy <= 1'b0;
			r_bvalid  <= 1'b0;
		end
		else
		begin
			if (i_awvalid && o_awready)
			begin
				r_wr_busy <= 1'b1;
				r_wr_adrs <= i_aw.addr;
			end
			if (q_w_fire)
			begin
				r_wr_adrs <= r_wr_adrs + `DDR_BUS_BYTES;
				if (i_w.last)
				begin
					r_wr_busy <= 1'b0;
					r_bvalid  <= 1'b1;	// Answer the burst
				end
			end
			if (r_bvalid && i_bready)
				r_bvalid <= 1'b0;
		end
	end

	always_ff @(posedge iCLK)
	begin
		if (q_w_fire)
			r_mem[beat_index(r_wr_adrs)] <= w_wr_data;
	end

	assign o_b.resp = lp_axi4_resp_okay;
	assign o_bvalid = r_bvalid;

	//----------------------------------------------------------------------
	// Read side
	//----------------------------------------------------------------------
	assign o_arready = !r_rd_busy && i_rand[2];
	assign q_r_fire  = r_rd_busy && i_rready;

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			r_rd_busy <= 1'b0;
		else if (i_arvalid && o_arready)
		begin
			r_rd_busy <= 1'b1;
			r_rd_adrs <= i_ar.addr;
			r_rd_len  <= i_ar.len;
			r_rd_cnt  <= 8'd0;
		end
		else if (q_r_fire)
		begin
			r_rd_adrs <= r_rd_adrs + `DDR_BUS_BYTES;
			r_rd_cnt  <= r_rd_cnt + 8'd1;
			if (r_rd_cnt == r_rd_len)
				r_rd_busy <= 1'b0;	// Burst drained
		end
	end

	// In-order beats straight from the array
	always_comb
	begin
		o_r.data = r_mem[beat_index(r_rd_adrs)];
		o_r.resp = lp_axi4_resp_okay;
		o_r.last = (r_rd_cnt == r_rd_len);
	end

	assign o_rvalid = r_rd_busy;

endmodule

/* rtl/ddr_test_top.sv */
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// DDR memory test engine top level
// Write pass, read pass and pattern check on an AXI4 master port
// Pulse i_start and wait for o_status.done
//--------------------------------------------------------------------------

module ddr_test_top import axi4_pkg::*, ddr_test_pkg::*; (
	input  logic        iCLK,
	input  logic        iRST,
	input  logic        i_start,
	// Write address channel
	output axi4_aw_t    o_aw,
	output logic        o_awvalid,
	input  logic        i_awready,
	// Write data channel
	output axi4_w_t     o_w,
	output logic        o_wvalid,
	input  logic        i_wready,
	// Write response channel
	input  axi4_b_t     i_b,
	input  logic        i_bvalid,
	output logic        o_bready,
	// Read address channel
	output axi4_ar_t    o_ar,
	output logic        o_arvalid,
	input  logic        i_arready,
	// Read data channel
	input  axi4_r_t     i_r,
	input  logic        i_rvalid,
	output logic        o_rready,
	output ddr_status_t o_status
);

	logic      w_wdone;		// Write pass complete
	ddr_beat_t w_beat;
	logic      w_beat_valid;
	logic      w_rd_end;

	axi4_write_sequence u_wr_seq (
		.iCLK      (iCLK),       .iRST      (iRST),
		.i_start   (i_start),
		.o_aw      (o_aw),       .o_awvalid (o_awvalid), .i_awready (i_awready),
		.o_w       (o_w),        .o_wvalid  (o_wvalid),  .i_wready  (i_wready),
		.i_b       (i_b),        .i_bvalid  (i_bvalid),  .o_bready  (o_bready),
		.o_wdone   (w_wdone)
	);

	axi4_read_sequence u_rd_seq (
		.iCLK         (iCLK),         .iRST      (iRST),
		.i_wdone      (w_wdone),
		.o_ar         (o_ar),         .o_arvalid (o_arvalid), .i_arready (i_arready),
		.i_r          (i_r),          .i_rvalid  (i_rvalid),  .o_rready  (o_rready),
		.o_beat       (w_beat),       .o_beat_valid (w_beat_valid),
		.o_rd_end     (w_rd_end)
	);

	// Never stalls the read side
	ddr_pattern_checker u_checker (
		.iCLK         (iCLK),
		.iRST         (iRST),
		.i_start      (i_start),
		.i_beat       (w_beat),
		.i_beat_valid (w_beat_valid),
		.i_rd_end     (w_rd_end),
		.o_status     (o_status)
	);

endmodule

/* rtl/ddr_pattern_checker.sv */
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// Compares read beats against the address pattern
// Counts mismatches and reports done and pass after the last beat
//--------------------------------------------------------------------------

module ddr_pattern_checker import ddr_test_pkg::*; (
	input  logic        iCLK,
	input  logic        iRST,
	input  logic        i_start,		// Clears the status
	input  ddr_beat_t   i_beat,
	input  logic        i_beat_valid,
	input  logic        i_rd_end,		// With the final beat
	output ddr_status_t o_status
);

	ddr_status_t r_status;
	logic        r_end_q;		// Final beat counted
	logic        q_mismatch;

	assign q_mismatch = i_beat_valid && (i_beat.data != ddr_pattern(i_beat.adrs));

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			r_status <= '0;
			r_end_q  <= 1'b0;
		end
		else if (i_start)
		begin
			r_status <= '0;
			r_end_q  <= 1'b0;
		end
		else
		begin
			// Saturating error count
			if (q_mismatch && !(&r_status.err_cnt))
				r_status.err_cnt <= r_status.err_cnt + 1'b1;
			r_end_q <= i_rd_end;
			if (r_end_q)
			begin
				r_status.done <= 1'b1;
				r_status.pass <= (r_status.err_cnt == 8'd0);	// Count already final
			end
		end
	end

	assign o_status = r_status;

endmodule

/* rtl/axi4_read_sequence.sv */
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// Read pass over the test region once the write pass is done
// Every accepted R beat goes to the checker with its byte address
//--------------------------------------------------------------------------
`include "ddr_test_defs.svh"

module axi4_read_sequence import axi4_pkg::*, ddr_test_pkg::*; (
	input  logic      iCLK,
	input  logic      iRST,
	input  logic      i_wdone,		// Level from the write side
	// Read address channel
	output axi4_ar_t  o_ar,
	output logic      o_arvalid,
	input  logic      i_arready,
	// Read data channel
	input  axi4_r_t   i_r,
	input  logic      i_rvalid,
	output logic      o_rready,
	// Checker side
	output ddr_beat_t o_beat,
	output logic      o_beat_valid,
	output logic      o_rd_end		// Last beat of the region
);

	logic          r_arvalid;
	logic          r_rready;		// Also marks a burst in flight
	logic          r_rd_fin;		// Region read for this wdone
	logic          r_beat_valid;
	logic          r_rd_end;
	ddr_beat_cnt_t r_beat_cnt;
	ddr_beat_t     r_beat;
	logic          q_r_fire;
	logic          q_burst_end;
	logic          q_rd_go;
	logic          q_arvalid_cke;
	logic          q_rready_cke;
	ddr_adrs_t     w_adrs;
	ddr_adrs_t     w_beat_adrs;
	logic          w_adrs_done;

	assign q_r_fire    = r_rready && i_rvalid;
	assign q_burst_end = q_r_fire && i_r.last;
	assign q_rd_go     = i_wdone && !r_rd_fin && !r_rready && !r_arvalid;	// Idle start
	assign w_beat_adrs = w_adrs + ddr_adrs_t'(r_beat_cnt) * `DDR_BUS_BYTES;

	// Steps on each burst's last beat
	axi4_adrs_generator u_adrs_gen (
		.iCLK        (iCLK),
		.iRST        (iRST),
		.i_step      (q_burst_end),
		.o_adrs      (w_adrs),
		.o_adrs_done (w_adrs_done)
	);

	//----------------------------------------------------------------------
	// Toggle control for AR valid and R ready
	//----------------------------------------------------------------------
	always_comb
	begin
		// Assert on start or back to back, drop on accept
		q_arvalid_cke = r_arvalid ? i_arready
			: (q_rd_go || (q_burst_end && !w_adrs_done));
		// Assert after AR accept, drop after the last beat
		q_rready_cke  = r_rready ? q_burst_end : (r_arvalid && i_arready);
	end

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			r_arvalid    <= 1'b0;
			r_rready     <= 1'b0;
			r_rd_fin     <= 1'b0;
			r_beat_valid <= 1'b0;
			r_rd_end     <= 1'b0;
			r_beat_cnt   <= '0;
		end
		else
		begin
			if (q_arvalid_cke)
				r_arvalid <= ~r_arvalid;
			if (q_rready_cke)
				r_rready <= ~r_rready;
			// Rearm when the next write pass begins
			if (!i_wdone)
				r_rd_fin <= 1'b0;
			else if (q_burst_end && w_adrs_done)
				r_rd_fin <= 1'b1;
			if (q_r_fire)
				r_beat_cnt <= i_r.last ? '0 : r_beat_cnt + 1'b1;
			r_beat_valid <= q_r_fire;
			r_rd_end     <= q_burst_end && w_adrs_done;
		end
	end

	// Beat capture
	always_ff @(posedge iCLK)
	begin
		if (q_r_fire)
		begin
			r_beat.adrs <= w_beat_adrs;
			// Error response shows up as bad data
			r_beat.data <= (i_r.resp == lp_axi4_resp_okay) ? i_r.data : ~i_r.data;
		end
	end

	always_comb
	begin
		o_ar.addr  = w_adrs;
		o_ar.len   = lp_axi4_len;
		o_ar.size  = lp_axi4_size;
		o_ar.burst = lp_axi4_burst_incr;
	end

	assign o_arvalid    = r_arvalid;
	assign o_rready     = r_rready;
	assign o_beat       = r_beat;
	assign o_beat_valid = r_beat_valid;
	assign o_rd_end     = r_rd_end;

	//----------------------------------------------------------------------
	// Checks
	//----------------------------------------------------------------------
	// Memory closes each burst on the fourth beat
	a_rlast_cnt : assert property (@(posedge iCLK) disable iff (iRST)
		q_r_fire |-> (i_r.last == (r_beat_cnt == ddr_last_beat)));

endmodule

/* rtl/axi4_write_sequence.sv */
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// Write pass over the test region in fixed-length INCR bursts
// Start with i_start and o_wdone stays high after the last B response
//--------------------------------------------------------------------------
`include "ddr_test_defs.svh"

module axi4_write_sequence import axi4_pkg::*, ddr_test_pkg::*; (
	input  logic     iCLK,
	input  logic     iRST,
	input  logic     i_start,
	// Write address channel
	output axi4_aw_t o_aw,
	output logic     o_awvalid,
	input  logic     i_awready,
	// Write data channel
	output axi4_w_t  o_w,
	output logic     o_wvalid,
	input  logic     i_wready,
	// Write response channel
	input  axi4_b_t  i_b,
	input  logic     i_bvalid,
	output logic     o_bready,
	output logic     o_wdone
);

	typedef enum logic [1:0] {WR_IDLE, WR_BURST, WR_RESP} wr_state_t;

	wr_state_t     r_state;
	logic          r_awvalid;
	logic          r_wvalid;
	ddr_beat_cnt_t r_beat_cnt;	// Next W beat in burst
	logic          r_wdone;
	logic          q_aw_fire;
	logic          q_w_fire;
	logic          q_w_last;
	logic          q_b_fire;
	ddr_adrs_t     w_adrs;		// Current burst start
	ddr_adrs_t     w_beat_adrs;
	logic          w_adrs_done;

	assign q_aw_fire   = r_awvalid && i_awready;
	assign q_w_fire    = r_wvalid && i_wready;
	assign q_w_last    = (r_beat_cnt == ddr_last_beat);
	assign q_b_fire    = i_bvalid && (r_state == WR_RESP);
	assign w_beat_adrs = w_adrs + ddr_adrs_t'(r_beat_cnt) * `DDR_BUS_BYTES;

	// Steps once per B response
	axi4_adrs_generator u_adrs_gen (
		.iCLK        (iCLK),
		.iRST        (iRST),
		.i_step      (q_b_fire),
		.o_adrs      (w_adrs),
		.o_adrs_done (w_adrs_done)
	);

	//----------------------------------------------------------------------
	// Burst FSM
	//----------------------------------------------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			r_state    <= WR_IDLE;
			r_awvalid  <= 1'b0;
			r_wvalid   <= 1'b0;
			r_beat_cnt <= '0;
			r_wdone    <= 1'b0;
		end
		else
		begin
			case (r_state)
			WR_IDLE:
				if (i_start)
				begin
					r_awvalid <= 1'b1;
					r_wvalid  <= 1'b1;	// Data goes with the address
					r_wdone   <= 1'b0;
					r_state   <= WR_BURST;
				end
			WR_BURST:
			begin
				if (q_aw_fire)
					r_awvalid <= 1'b0;
				if (q_w_fire)
				begin
					r_beat_cnt <= r_beat_cnt + 1'b1;	// Wraps after last
					if (q_w_last)
						r_wvalid <= 1'b0;
				end
				// Both address and last beat accepted
				if ((!r_awvalid || q_aw_fire) && (!r_wvalid || (q_w_fire && q_w_last)))
					r_state <= WR_RESP;
			end
			WR_RESP:
				if (q_b_fire)
				begin
					if (w_adrs_done)
					begin
						r_wdone <= 1'b1;	// Region written
						r_state <= WR_IDLE;
					end
					else
					begin
						r_awvalid <= 1'b1;
						r_wvalid  <= 1'b1;
						r_state   <= WR_BURST;
					end
				end
			default:
				r_state <= WR_IDLE;
			endcase
		end
	end

	// Channel payloads from held state
	always_comb
	begin
		o_aw.addr  = w_adrs;
		o_aw.len   = lp_axi4_len;
		o_aw.size  = lp_axi4_size;
		o_aw.burst = lp_axi4_burst_incr;
		o_w.data   = ddr_pattern(w_beat_adrs);
		o_w.strb   = '1;	// Full beat
		o_w.last   = q_w_last;
	end

	assign o_awvalid = r_awvalid;
	assign o_wvalid  = r_wvalid;
	assign o_bready  = (r_state != WR_IDLE);	// Open for the whole pass
	assign o_wdone   = r_wdone;

	//----------------------------------------------------------------------
	// Checks
	//----------------------------------------------------------------------
	a_aw_hold : assert property (@(posedge iCLK) disable iff (iRST)
		(r_awvalid && !i_awready) |=> (r_awvalid && $stable(o_aw)));

	// Memory answers only after a full burst and with OKAY
	a_b_order : assert property (@(posedge iCLK) disable iff (iRST)
		i_bvalid |-> ((r_state == WR_RESP) && (i_b.resp == lp_axi4_resp_okay)));

endmodule

/* rtl/axi4_adrs_generator.sv */
`timescale 1ns/1ps
//--------------------------------------------------------------------------
// Burst start address counter for one pass over the test region
// Each step moves one burst ahead and the last step wraps to the start
//--------------------------------------------------------------------------
`include "ddr_test_defs.svh"

module axi4_adrs_generator (
	input  logic                       iCLK,
	input  logic                       iRST,
	input  logic                       i_step,		// One burst completed
	output logic [`DDR_ADRS_WIDTH-1:0] o_adrs,
	output logic                       o_adrs_done	// Step that ends the pass
);

	logic [`DDR_ADRS_WIDTH-1:0] w_adrs_next;

	assign w_adrs_next = o_adrs + `DDR_BURST_BYTES;

	// Stepped address hits the exclusive stop
	assign o_adrs_done = i_step && (w_adrs_next == `DDR_STOP_ADRS);

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			o_adrs <= `DDR_START_ADRS;
		else if (o_adrs_done)
			o_adrs <= `DDR_START_ADRS;	// Wrap for the next pass
		else if (i_step)
			o_adrs <= w_adrs_next;
	end

	//----------------------------------------------------------------------
	// Checks
	//----------------------------------------------------------------------
	// Stop address never held and the final step lands on the start
	a_adrs_wrap : assert property (@(posedge iCLK) disable iff (iRST)
		i_step |=> (o_adrs < `DDR_STOP_ADRS)
			&& (!$past(o_adrs_done) || (o_adrs == `DDR_START_ADRS)));

endmodule

/* rtl/ddr_test_pkg.sv */
//--------------------------------------------------------------------------
// Test-side types and the address-derived data pattern
// Shared by the write sequencer, the checker and the bench
//--------------------------------------------------------------------------
`include "ddr_test_defs.svh"

package ddr_test_pkg;

	typedef logic [`DDR_ADRS_WIDTH-1:0] ddr_adrs_t;

	// Beat index inside one burst
	localparam int ddr_beat_bits = $clog2(`DDR_BURST_LEN);
	typedef logic [ddr_beat_bits-1:0] ddr_beat_cnt_t;
	localparam ddr_beat_cnt_t ddr_last_beat = ddr_beat_cnt_t'(`DDR_BURST_LEN - 1);

	// Read beat handed to the checker
	typedef struct packed {
		ddr_adrs_t                 adrs;	// Byte address of the beat
		logic [`DDR_BUS_WIDTH-1:0] data;
	} ddr_beat_t;

	typedef struct packed {
		logic       done;
		logic       pass;	// Valid once done is set
		logic [7:0] err_cnt;	// Saturates at 255
	} ddr_status_t;

	// Lane k = ((adrs[15:0] >> 1) + k) ^ key
	function automatic logic [`DDR_BUS_WIDTH-1:0] ddr_pattern(input ddr_adrs_t adrs);
		logic [`DDR_BUS_WIDTH-1:0]  data;
		logic [`DDR_LANE_WIDTH-1:0] base;
		logic [`DDR_LANE_WIDTH-1:0] lane;
		int                         k;
		base = adrs[`DDR_LANE_WIDTH-1:0] >> 1;
		for (k = 0; k < `DDR_LANES; k++)
		begin
			lane = base + k[`DDR_LANE_WIDTH-1:0];
			data[k*`DDR_LANE_WIDTH +: `DDR_LANE_WIDTH] = lane ^ `DDR_PATTERN_KEY;
		end
		return data;
	endfunction

endpackage

/* rtl/axi4_pkg.sv */
//--------------------------------------------------------------------------
// AXI4 channel payloads between the test engine and the DDR port
// Import into any module that drives or samples an AXI4 channel
//--------------------------------------------------------------------------
`include "ddr_test_defs.svh"

package axi4_pkg;

	// Fixed burst fields
	localparam logic [7:0] lp_axi4_len        = 8'(`DDR_BURST_LEN - 1);
	localparam logic [2:0] lp_axi4_size       = 3'($clog2(`DDR_BUS_BYTES));
	localparam logic [1:0] lp_axi4_burst_incr = 2'b01;	// Address auto increment
	localparam logic [1:0] lp_axi4_resp_okay  = 2'b00;

	// AW and AR share one layout
	typedef struct packed {
		logic [`DDR_ADRS_WIDTH-1:0] addr;
		logic [7:0]                 len;	// Beats less one
		logic [2:0]                 size;	// Log2 of bytes per beat
		logic [1:0]                 burst;
	} axi4_ax_t;

	typedef axi4_ax_t axi4_aw_t;
	typedef axi4_ax_t axi4_ar_t;

	// Write beat
	typedef struct packed {
		logic [`DDR_BUS_WIDTH-1:0] data;
		logic [`DDR_BUS_BYTES-1:0] strb;
		logic                      last;
	} axi4_w_t;

	// Read beat
	typedef struct packed {
		logic [`DDR_BUS_WIDTH-1:0] data;
		logic [1:0]                resp;
		logic                      last;
	} axi4_r_t;

	// Write response
	typedef struct packed {
		logic [1:0] resp;
	} axi4_b_t;

endpackage

/* rtl/ddr_test_defs.svh */
//--------------------------------------------------------------------------
// Build constants for the DDR memory test engine
// Bus and lane widths, burst shape and the tested address region
// Include wherever one of these constants is referenced
//--------------------------------------------------------------------------
`ifndef DDR_TEST_DEFS_SVH
`define DDR_TEST_DEFS_SVH

// AXI data path
`define DDR_BUS_WIDTH   64
`define DDR_BUS_BYTES   (`DDR_BUS_WIDTH / 8)
`define DDR_ADRS_WIDTH  32

// Pattern lanes within one beat
`define DDR_LANE_WIDTH  16
`define DDR_LANES       (`DDR_BUS_WIDTH / `DDR_LANE_WIDTH)
`define DDR_PATTERN_KEY 16'hA5C3

// Fixed INCR bursts
`define DDR_BURST_LEN   4
`define DDR_BURST_BYTES (`DDR_BURST_LEN * `DDR_BUS_BYTES)

// Test region with exclusive stop
`define DDR_START_ADRS  32'h0000_0000
`define DDR_STOP_ADRS   32'h0000_0400

`endif
